// ==== common/vec_cache_consts.svh ====
`ifndef VEC_CACHE_CONSTS_SVH
`define VEC_CACHE_CONSTS_SVH

// ----------------------------------------
// data RAM
// ----------------------------------------
`define VC_DATA_WIDTH       64
`define VC_RAM_DEPTH        64

// request accept to data at RAM output
`define VC_READ_SRAM_DELAY  4

// ----------------------------------------
// read data buffer
// ----------------------------------------
// split evenly over the two ping-pong banks
`define VC_RDB_ENTRY_NUM    16

// ids carried with each read
`define VC_ROB_ID_WIDTH     5
`define VC_TXNID_WIDTH      8

`endif

// ==== common/vec_cache_pkg.sv ====
`default_nettype none

`include "vec_cache_consts.svh"

package vec_cache_pkg;

    // ----------------------------------------
    // per-read metadata
    // ----------------------------------------
    // travels with the line from request to upstream port
    typedef struct packed {
        logic [`VC_ROB_ID_WIDTH-1:0] rob_entry_id;
        logic [`VC_TXNID_WIDTH-1:0]  txnid;
    } rd_meta_t;

    // ----------------------------------------
    // ping-pong bank select
    // ----------------------------------------
    typedef enum logic {
        BANK0 = 1'b0,
        BANK1 = 1'b1
    } rdb_bank_e;

endpackage

`default_nettype wire

// ==== common/vec_cache_if.sv ====
`default_nettype none

`include "vec_cache_consts.svh"

// read request into the data RAM
interface rd_req_if;
    import vec_cache_pkg::*;

    logic                             vld;
    logic                             rdy;
    logic [$clog2(`VC_RAM_DEPTH)-1:0] addr;
    rd_meta_t                         meta;

    modport src (output vld, output addr, output meta, input rdy);
    modport ram (input vld, input addr, input meta, output rdy);
endinterface

// RAM response towards the RDB, no ready on this path
interface ram_rsp_if;
    import vec_cache_pkg::*;

    logic                      vld;
    logic [`VC_DATA_WIDTH-1:0] data;
    rd_meta_t                  meta;
    logic                      entry_free;

    modport ram (output vld, output data, output meta, input entry_free);
    modport rdb (input vld, input data, input meta, output entry_free);
endinterface

`default_nettype wire

// ==== src/vec_cache_dataram.sv ====
`default_nettype none

`include "vec_cache_consts.svh"

module vec_cache_dataram (
    input  logic                             clk,
    input  logic                             rst_n,
    rd_req_if.ram                            req,
    ram_rsp_if.ram                           rsp,
    input  logic                             fill_en,
    input  logic [$clog2(`VC_RAM_DEPTH)-1:0] fill_addr,
    input  logic [`VC_DATA_WIDTH-1:0]        fill_data
);
    import vec_cache_pkg::*;

    localparam int DLY      = `VC_READ_SRAM_DELAY;
    localparam int CREDIT_W = $clog2(`VC_RDB_ENTRY_NUM) + 1;

    logic [`VC_DATA_WIDTH-1:0] mem [`VC_RAM_DEPTH];
    logic                      accept;
    logic [CREDIT_W-1:0]       credit;
    logic [DLY-1:0]            pipe_vld;
    logic [`VC_DATA_WIDTH-1:0] pipe_data [DLY];
    rd_meta_t                  pipe_meta [DLY];

    assign accept  = req.vld && req.rdy;
    assign req.rdy = (credit != '0);

    // ----------------------------------------
    // storage and read pipeline
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (fill_en) begin
            mem[fill_addr] <= fill_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld <= {pipe_vld[DLY-2:0], accept};
        end
    end

    // payload shifts every cycle, qualified by pipe_vld
    always_ff @(posedge clk) begin
        pipe_data[0] <= mem[req.addr];
        pipe_meta[0] <= req.meta;
        for (int i = 1; i < DLY; i++) begin
            pipe_data[i] <= pipe_data[i-1];
            pipe_meta[i] <= pipe_meta[i-1];
        end
    end

    assign rsp.vld  = pipe_vld[DLY-1];
    assign rsp.data = pipe_data[DLY-1];
    assign rsp.meta = pipe_meta[DLY-1];

    // ----------------------------------------
    // request credits
    // ----------------------------------------
    // one credit per RDB entry, returned on entry_free
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= CREDIT_W'(`VC_RDB_ENTRY_NUM);
        end else begin
            credit <= credit - CREDIT_W'(accept) + CREDIT_W'(rsp.entry_free);
        end
    end

    // an underflow would wrap above the entry count as well
    assert property (@(posedge clk) disable iff (!rst_n)
        credit <= CREDIT_W'(`VC_RDB_ENTRY_NUM));

endmodule

`default_nettype wire

// ==== rdb/vec_cache_pre_alloc_one.sv ====
`default_nettype none

module vec_cache_pre_alloc_one #(
    parameter int ENTRY_NUM = 8
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [ENTRY_NUM-1:0]         v_in_vld,
    output logic [ENTRY_NUM-1:0]         v_in_rdy,
    output logic                         out_vld,
    input  logic                         out_rdy,
    output logic [$clog2(ENTRY_NUM)-1:0] out_index
);

    localparam int IDX_W = $clog2(ENTRY_NUM);

    logic                 take;
    logic [ENTRY_NUM-1:0] cand;
    logic                 cand_any;
    logic [IDX_W-1:0]     cand_idx;

    assign take = out_vld && out_rdy;

    // claim the offered entry when it is taken
    always_comb begin
        v_in_rdy = '0;
        if (take) begin
            v_in_rdy[out_index] = 1'b1;
        end
    end

    // the claimed entry is still marked idle this cycle
    assign cand = v_in_vld & ~v_in_rdy;

    // lowest idle entry
    always_comb begin
        cand_any = 1'b0;
        cand_idx = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (cand[i]) begin
                cand_any = 1'b1;
                cand_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld   <= 1'b0;
            out_index <= '0;
        end else if (!out_vld || take) begin
            out_vld   <= cand_any;
            out_index <= cand_idx;
        end
    end

endmodule

`default_nettype wire

// ==== rdb/vec_cache_rdb_bank.sv ====
`default_nettype none

module vec_cache_rdb_bank #(
    parameter int ADDR_WIDTH = 3,
    parameter int DATA_WIDTH = 64
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic [DATA_WIDTH-1:0] rd_data
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // single port, read data one cycle after a read enable
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                mem[addr] <= wr_data;
            end else begin
                rd_data <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== rdb/vec_cache_rdb_agent.sv ====
`default_nettype none

`include "vec_cache_consts.svh"

module vec_cache_rdb_agent (
    input  logic                         clk,
    input  logic                         rst_n,
    ram_rsp_if.rdb                       rsp,
    input  logic                         us_rdy,
    output logic                         us_data_vld,
    output logic [`VC_DATA_WIDTH-1:0]    us_data,
    output vec_cache_pkg::rd_meta_t      us_meta,
    output logic                         us_done,
    output logic [`VC_ROB_ID_WIDTH-1:0]  us_done_idx
);
    import vec_cache_pkg::*;

    localparam int BANK_ENTRY = `VC_RDB_ENTRY_NUM / 2;
    localparam int IDX_W      = $clog2(BANK_ENTRY);
    localparam int Q_DEPTH    = `VC_RDB_ENTRY_NUM;
    localparam int Q_PTR_W    = $clog2(Q_DEPTH);

    typedef struct packed {
        rdb_bank_e        bank;
        logic [IDX_W-1:0] idx;
        rd_meta_t         meta;
    } rdq_entry_t;

    rdb_bank_e                 wr_sel;
    logic                      alloc_vld [2];
    logic [IDX_W-1:0]          alloc_idx [2];
    logic [`VC_DATA_WIDTH-1:0] bank_rd_data [2];

    rdq_entry_t                q_mem [Q_DEPTH];
    rdq_entry_t                q_push;
    rdq_entry_t                q_head;
    logic [Q_PTR_W-1:0]        q_wr_ptr;
    logic [Q_PTR_W-1:0]        q_rd_ptr;
    logic [Q_PTR_W:0]          q_cnt;

    logic                      rd_go;
    logic                      out_vld;
    rdb_bank_e                 out_bank;

    // writes own both banks for the cycle
    assign rd_go          = (q_cnt != '0) && us_rdy && !rsp.vld;
    assign rsp.entry_free = rd_go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_sel <= BANK0;
        end else if (rsp.vld) begin
            wr_sel <= (wr_sel == BANK0) ? BANK1 : BANK0;
        end
    end

    // ----------------------------------------
    // per-bank allocation and storage
    // ----------------------------------------
    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [BANK_ENTRY-1:0] idle;
        logic [BANK_ENTRY-1:0] claim;
        logic                  wr_hit;
        logic                  rd_hit;

        assign wr_hit = rsp.vld && (wr_sel == rdb_bank_e'(b));
        assign rd_hit = rd_go && (q_head.bank == rdb_bank_e'(b));

        // entry goes busy on claim, idle again once read out
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                idle <= '1;
            end else if (wr_hit) begin
                idle <= idle & ~claim;
            end else if (rd_hit) begin
                idle[q_head.idx] <= 1'b1;
            end
        end

        vec_cache_pre_alloc_one #(
            .ENTRY_NUM (BANK_ENTRY)
        ) u_pre_alloc (
            .clk       (clk),
            .rst_n     (rst_n),
            .v_in_vld  (idle),
            .v_in_rdy  (claim),
            .out_vld   (alloc_vld[b]),
            .out_rdy   (wr_hit),
            .out_index (alloc_idx[b])
        );

        vec_cache_rdb_bank #(
            .ADDR_WIDTH (IDX_W),
            .DATA_WIDTH (`VC_DATA_WIDTH)
        ) u_bank (
            .clk     (clk),
            .en      (wr_hit || rd_hit),
            .wr_en   (wr_hit),
            .addr    (wr_hit ? alloc_idx[b] : q_head.idx),
            .wr_data (rsp.data),
            .rd_data (bank_rd_data[b])
        );
    end

    // ----------------------------------------
    // readout queue, in arrival order
    // ----------------------------------------
    assign q_push.bank = wr_sel;
    assign q_push.idx  = alloc_idx[wr_sel];
    assign q_push.meta = rsp.meta;
    assign q_head      = q_mem[q_rd_ptr];

    always_ff @(posedge clk) begin
        if (rsp.vld) begin
            q_mem[q_wr_ptr] <= q_push;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_cnt    <= '0;
        end else begin
            if (rsp.vld) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (rd_go) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            q_cnt <= q_cnt + (Q_PTR_W + 1)'(rsp.vld) - (Q_PTR_W + 1)'(rd_go);
        end
    end

    // ----------------------------------------
    // upstream output
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else begin
            out_vld <= rd_go;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            out_bank    <= q_head.bank;
            us_meta     <= q_head.meta;
            us_done_idx <= q_head.meta.rob_entry_id;
        end
    end

    assign us_data_vld = out_vld;
    assign us_done     = out_vld;
    assign us_data     = bank_rd_data[out_bank];

    // credits in the RAM must keep a free entry ready for every response
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.vld |-> alloc_vld[wr_sel]);

    // push while full would overwrite the oldest line
    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.vld |-> (q_cnt < (Q_PTR_W + 1)'(Q_DEPTH)));

endmodule

`default_nettype wire

// ==== src/vec_cache_rd_top.sv ====
`default_nettype none

`include "vec_cache_consts.svh"

module vec_cache_rd_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             rd_vld,
    input  logic [$clog2(`VC_RAM_DEPTH)-1:0] rd_addr,
    input  logic [`VC_ROB_ID_WIDTH-1:0]      rd_rob_id,
    input  logic [`VC_TXNID_WIDTH-1:0]       rd_txnid,
    output logic                             rd_rdy,
    input  logic                             us_rdy,
    output logic                             us_data_vld,
    output logic [`VC_DATA_WIDTH-1:0]        us_data,
    output logic [`VC_ROB_ID_WIDTH-1:0]      us_rob_id,
    output logic [`VC_TXNID_WIDTH-1:0]       us_txnid,
    output logic                             us_done,
    output logic [`VC_ROB_ID_WIDTH-1:0]      us_done_idx,
    input  logic                             fill_en,
    input  logic [$clog2(`VC_RAM_DEPTH)-1:0] fill_addr,
    input  logic [`VC_DATA_WIDTH-1:0]        fill_data
);
    import vec_cache_pkg::*;

    rd_meta_t us_meta;

    rd_req_if  req_if ();
    ram_rsp_if rsp_if ();

    // request side
    assign req_if.vld               = rd_vld;
    assign req_if.addr              = rd_addr;
    assign req_if.meta.rob_entry_id = rd_rob_id;
    assign req_if.meta.txnid        = rd_txnid;
    assign rd_rdy                   = req_if.rdy;

    vec_cache_dataram u_dataram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_if.ram),
        .rsp       (rsp_if.ram),
        .fill_en   (fill_en),
        .fill_addr (fill_addr),
        .fill_data (fill_data)
    );

    vec_cache_rdb_agent u_rdb_agent (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp         (rsp_if.rdb),
        .us_rdy      (us_rdy),
        .us_data_vld (us_data_vld),
        .us_data     (us_data),
        .us_meta     (us_meta),
        .us_done     (us_done),
        .us_done_idx (us_done_idx)
    );

    // upstream ids
    assign us_rob_id = us_meta.rob_entry_id;
    assign us_txnid  = us_meta.txnid;

endmodule

`default_nettype wire

// ==== verification/tb_vec_cache_rd.sv ====
`default_nettype none

`include "vec_cache_consts.svh"

module tb_vec_cache_rd;

    localparam int AW        = $clog2(`VC_RAM_DEPTH);
    localparam int N_BURST   = 12;
    localparam int N_RAND    = 200;
    localparam int N_REQ     = 1 + N_BURST + `VC_RDB_ENTRY_NUM + N_RAND;
    localparam int MAX_CYC   = 2 * N_REQ * (`VC_READ_SRAM_DELAY + 4) + 200;
    localparam int MIN_LAT   = `VC_READ_SRAM_DELAY + 2;
    localparam int DRAIN_LIM = 2 * `VC_RDB_ENTRY_NUM + MIN_LAT;

    typedef struct packed {
        logic [`VC_DATA_WIDTH-1:0]   data;
        logic [`VC_ROB_ID_WIDTH-1:0] rob_id;
        logic [`VC_TXNID_WIDTH-1:0]  txnid;
    } line_t;

    logic                        clk;
    logic                        rst_n;
    logic                        rd_vld;
    logic [AW-1:0]               rd_addr;
    logic [`VC_ROB_ID_WIDTH-1:0] rd_rob_id;
    logic [`VC_TXNID_WIDTH-1:0]  rd_txnid;
    logic                        rd_rdy;
    logic                        us_rdy;
    logic                        us_data_vld;
    logic [`VC_DATA_WIDTH-1:0]   us_data;
    logic [`VC_ROB_ID_WIDTH-1:0] us_rob_id;
    logic [`VC_TXNID_WIDTH-1:0]  us_txnid;
    logic                        us_done;
    logic [`VC_ROB_ID_WIDTH-1:0] us_done_idx;
    logic                        fill_en;
    logic [AW-1:0]               fill_addr;
    logic [`VC_DATA_WIDTH-1:0]   fill_data;

    logic [`VC_DATA_WIDTH-1:0] shadow [`VC_RAM_DEPTH];
    line_t       exp_q [$];
    int          acc_cyc_q [$];
    int          cycle;
    int          n_checks;
    int          n_errors;
    int          seq;
    int          gap;
    int          n_acc;
    int          n_wait;
    logic        took;
    logic        hold_phase;
    logic        rand_rdy;
    logic [31:0] rnd;
    logic [31:0] rdy_rnd;

    vec_cache_rd_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_vld      (rd_vld),
        .rd_addr     (rd_addr),
        .rd_rob_id   (rd_rob_id),
        .rd_txnid    (rd_txnid),
        .rd_rdy      (rd_rdy),
        .us_rdy      (us_rdy),
        .us_data_vld (us_data_vld),
        .us_data     (us_data),
        .us_rob_id   (us_rob_id),
        .us_txnid    (us_txnid),
        .us_done     (us_done),
        .us_done_idx (us_done_idx),
        .fill_en     (fill_en),
        .fill_addr   (fill_addr),
        .fill_data   (fill_data)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // what the upstream port should return for one accepted request
    function automatic line_t expected_line(input logic [AW-1:0] addr,
                                            input logic [`VC_ROB_ID_WIDTH-1:0] rob,
                                            input logic [`VC_TXNID_WIDTH-1:0] txn);
        line_t l;
        l.data   = shadow[addr];
        l.rob_id = rob;
        l.txnid  = txn;
        return l;
    endfunction

    task automatic finish_run(input logic timed_out);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic next_edge();
        @(posedge clk);
        #10;
    endtask

    task automatic fill_memory();
        logic [`VC_DATA_WIDTH-1:0] word;
        for (int a = 0; a < `VC_RAM_DEPTH; a++) begin
            rnd = lcg_next(rnd);
            word[63:32] = rnd;
            rnd = lcg_next(rnd);
            word[31:0] = rnd;
            shadow[a] = word;
            fill_en   = 1'b1;
            fill_addr = AW'(a);
            fill_data = word;
            next_edge();
        end
        fill_en = 1'b0;
    endtask

    // rob ids count up so that reordering shows
    task automatic load_request();
        rnd = lcg_next(rnd);
        rd_addr   = rnd[8 +: AW];
        rd_txnid  = rnd[23:16];
        rd_rob_id = seq[4:0];
        seq++;
    endtask

    task automatic send_read();
        logic acc;
        rd_vld = 1'b1;
        load_request();
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = rd_rdy;
            next_edge();
        end
        rd_vld = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #10;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle = 0;
        while (cycle < MAX_CYC) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYC);
        n_errors++;
        finish_run(1'b1);
    end

    // random upstream ready, about three cycles in four
    initial begin
        rdy_rnd = 32'h4bb3a296;
        forever begin
            next_edge();
            if (rand_rdy) begin
                rdy_rnd = lcg_next(rdy_rnd);
                us_rdy  = (rdy_rnd[29:28] != 2'b00);
            end
        end
    end

    // ----------------------------------------
    // comparison against the reference
    // ----------------------------------------
    always @(negedge clk) begin : check_outputs
        line_t exp;
        int    lat;
        if (rst_n) begin
            assert (us_done == us_data_vld) else begin
                $display("FAILED us_done: got %h expected %h", us_done, us_data_vld);
                n_errors++;
            end
            assert (!(hold_phase && us_data_vld)) else begin
                $display("upstream output appeared while us_rdy was held low");
                n_errors++;
            end
            if (us_data_vld) begin
                assert (exp_q.size() != 0) else begin
                    $display("upstream output arrived with no request outstanding");
                    n_errors++;
                end
                if (exp_q.size() != 0) begin
                    exp = exp_q.pop_front();
                    lat = cycle - acc_cyc_q.pop_front();
                    n_checks++;
                    assert (us_data == exp.data) else begin
                        $display("FAILED us_data: got %h expected %h", us_data, exp.data);
                        n_errors++;
                    end
                    assert (us_rob_id == exp.rob_id) else begin
                        $display("FAILED us_rob_id: got %h expected %h", us_rob_id, exp.rob_id);
                        n_errors++;
                    end
                    assert (us_txnid == exp.txnid) else begin
                        $display("FAILED us_txnid: got %h expected %h", us_txnid, exp.txnid);
                        n_errors++;
                    end
                    assert (us_done_idx == exp.rob_id) else begin
                        $display("FAILED us_done_idx: got %h expected %h",
                                 us_done_idx, exp.rob_id);
                        n_errors++;
                    end
                    assert (lat >= MIN_LAT) else begin
                        $display("line returned after %0d cycles, below the minimum of %0d",
                                 lat, MIN_LAT);
                        n_errors++;
                    end
                end
            end
            if (rd_vld && rd_rdy) begin
                exp_q.push_back(expected_line(rd_addr, rd_rob_id, rd_txnid));
                acc_cyc_q.push_back(cycle);
            end
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        rst_n      = 1'b0;
        rd_vld     = 1'b0;
        rd_addr    = '0;
        rd_rob_id  = '0;
        rd_txnid   = '0;
        us_rdy     = 1'b0;
        fill_en    = 1'b0;
        fill_addr  = '0;
        fill_data  = '0;
        hold_phase = 1'b0;
        rand_rdy   = 1'b0;
        n_checks   = 0;
        n_errors   = 0;
        seq        = 0;
        n_wait     = 0;
        rnd        = 32'h4bb3a296;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;

        @(negedge clk);
        assert (rd_rdy) else begin
            $display("FAILED rd_rdy: got %h expected %h", rd_rdy, 1'b1);
            n_errors++;
        end
        assert (!us_data_vld && !us_done) else begin
            $display("upstream output active after reset");
            n_errors++;
        end
        next_edge();
        fill_memory();

        // single read, then a back-to-back burst
        us_rdy = 1'b1;
        send_read();
        wait_drained();
        repeat (N_BURST) send_read();
        wait_drained();

        // stalled upstream, credits run out
        us_rdy     = 1'b0;
        hold_phase = 1'b1;
        n_acc      = 0;
        rd_vld     = 1'b1;
        load_request();
        repeat (2 * `VC_RDB_ENTRY_NUM) begin
            @(negedge clk);
            took = rd_rdy;
            next_edge();
            if (took) begin
                n_acc++;
                load_request();
            end
        end
        rd_vld = 1'b0;
        @(negedge clk);
        assert (n_acc == `VC_RDB_ENTRY_NUM) else begin
            $display("FAILED accepted count: got %h expected %h", n_acc, `VC_RDB_ENTRY_NUM);
            n_errors++;
        end
        assert (!rd_rdy) else begin
            $display("FAILED rd_rdy: got %h expected %h", rd_rdy, 1'b0);
            n_errors++;
        end
        next_edge();
        hold_phase = 1'b0;
        us_rdy     = 1'b1;
        wait_drained();
        @(negedge clk);
        assert (rd_rdy) else begin
            $display("rd_rdy did not return after the buffer drained");
            n_errors++;
        end
        next_edge();

        // random gaps and random upstream ready
        rand_rdy = 1'b1;
        repeat (N_RAND) begin
            rnd = lcg_next(rnd);
            gap = int'(rnd[27:26]);
            repeat (gap) next_edge();
            send_read();
        end
        rand_rdy = 1'b0;
        next_edge();
        us_rdy = 1'b1;

        // every outstanding line must be out well within this bound
        while (exp_q.size() != 0 && n_wait < DRAIN_LIM) begin
            @(posedge clk);
            n_wait++;
        end
        repeat (20) @(posedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%0d expected lines never came out", exp_q.size());
            n_errors++;
        end
        finish_run(1'b0);
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/vec_cache_pkg.sv
common/vec_cache_if.sv
src/vec_cache_dataram.sv
rdb/vec_cache_pre_alloc_one.sv
rdb/vec_cache_rdb_bank.sv
rdb/vec_cache_rdb_agent.sv
src/vec_cache_rd_top.sv
verification/tb_vec_cache_rd.sv

// ==== Makefile ====
TOP := tb_vec_cache_rd

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
